// ==== memSys_macros.svh ====
`ifndef MEMSYS_MACROS_SVH
`define MEMSYS_MACROS_SVH

// words per cache line and per memory block
`define BLOCK_WORDS 4

// memory wait cycles, counted from the accept cycle
`define WAIT_CYCLES 2

// number of direct-mapped cache lines
`define CACHE_LINES 8

// memory depth in words, as a power of two
`define MEM_WORDS_LOG2 12

// line request FIFO entries
// two lets a writeback and a fill be queued together
`define FIFO_DEPTH 2

`endif

// ==== memSysPkg.sv ====
`include "memSys_macros.svh"

package memSysPkg;

  // data word and cpu byte address
  typedef logic [31:0] wordT;
  typedef logic [31:0] byteAddrT;

  // word address without the two word-offset bits
  typedef logic [`MEM_WORDS_LOG2-3:0] lineAddrT;

  // whole line, word 0 in the low bits
  typedef logic [`BLOCK_WORDS*32-1:0] lineDataT;

  // single word access, slave port to cache
  typedef struct packed {
    logic     write;
    byteAddrT addr;
    wordT     wdata;
  } wordReqT;

  // whole line access, cache through FIFO to memory
  typedef struct packed {
    logic     write;
    lineAddrT lineAddr;
    lineDataT data;
  } lineReqT;

  // slave port FSM
  typedef enum logic [1:0] {AXI_IDLE, AXI_BUSY, AXI_RESP} axiStateT;

  // cache controller FSM
  typedef enum logic [2:0] {
    CACHE_IDLE, CACHE_LOOKUP, CACHE_WRITEBACK, CACHE_FILL, CACHE_WAITFILL, CACHE_DONE
  } cacheStateT;

  // memory model FSM
  typedef enum logic [1:0] {MEM_IDLE, MEM_WAITING, MEM_RETURN} memStateT;

endpackage

// ==== axiLiteSlave.sv ====
module axiLiteSlave
(
  input  logic                clk,
  input  logic                rstN,
  input  logic                awvalid,
  input  memSysPkg::byteAddrT awaddr,
  input  logic                wvalid,
  input  memSysPkg::wordT     wdata,
  input  logic                arvalid,
  input  memSysPkg::byteAddrT araddr,
  input  logic                bready,
  input  logic                rready,
  output logic                awready,
  output logic                wready,
  output logic                arready,
  output logic                bvalid,
  output logic                rvalid,
  output memSysPkg::wordT     rdata,
  output logic                reqValid,
  output memSysPkg::wordReqT  req,
  input  logic                reqReady,
  input  logic                doneValid,
  input  memSysPkg::wordT     doneData
);

  memSysPkg::axiStateT state;
  logic wrAccept;
  logic rdAccept;
  logic respTaken;

  // write needs both aw and w, and wins over a read in the same cycle
  assign wrAccept = (state == memSysPkg::AXI_IDLE) && awvalid && wvalid;
  assign rdAccept = (state == memSysPkg::AXI_IDLE) && arvalid && !(awvalid && wvalid);
  assign awready = wrAccept;
  assign wready = wrAccept;
  assign arready = rdAccept;

  // master took whichever response is up
  assign respTaken = (bvalid && bready) || (rvalid && rready);

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= memSysPkg::AXI_IDLE;
      reqValid <= 1'b0;
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end
    else
    begin
      case (state)
        memSysPkg::AXI_IDLE:
        begin
          if (wrAccept || rdAccept)
          begin
            state <= memSysPkg::AXI_BUSY;
            reqValid <= 1'b1;
          end
        end
        memSysPkg::AXI_BUSY:
        begin
          // drop valid once the cache has it
          if (reqValid && reqReady)
          begin
            reqValid <= 1'b0;
          end
          // completion goes out one cycle after done
          if (doneValid)
          begin
            state <= memSysPkg::AXI_RESP;
            bvalid <= req.write;
            rvalid <= !req.write;
          end
        end
        memSysPkg::AXI_RESP:
        begin
          // held until the master is ready
          if (respTaken)
          begin
            state <= memSysPkg::AXI_IDLE;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
          end
        end
        default:
        begin
          state <= memSysPkg::AXI_IDLE;
        end
      endcase
    end
  end

  // request and read data payload
  always_ff @(posedge clk)
  begin
    if (wrAccept)
    begin
      req <= '{write: 1'b1, addr: awaddr, wdata: wdata};
    end
    else if (rdAccept)
    begin
      req <= '{write: 1'b0, addr: araddr, wdata: '0};
    end
    // stays stable through RESP
    if (state == memSysPkg::AXI_BUSY && doneValid)
    begin
      rdata <= doneData;
    end
  end

endmodule

// ==== cacheCtrl.sv ====
`include "memSys_macros.svh"

module cacheCtrl
(
  input  logic                clk,
  input  logic                rstN,
  input  logic                reqValid,
  input  memSysPkg::wordReqT  req,
  output logic                reqReady,
  output logic                doneValid,
  output memSysPkg::wordT     doneData,
  output logic                pushValid,
  output memSysPkg::lineReqT  push,
  input  logic                pushReady,
  input  logic                fillValid,
  input  memSysPkg::lineDataT fillData
);

  // address split: tag | index | word offset | byte
  localparam int offBits = $clog2(`BLOCK_WORDS);
  localparam int idxBits = $clog2(`CACHE_LINES);
  localparam int lineBits = $bits(memSysPkg::lineAddrT);
  localparam int tagBits = lineBits - idxBits;

  memSysPkg::cacheStateT state;
  memSysPkg::wordReqT curReq;
  memSysPkg::wordT rdData;

  // line storage
  logic [tagBits-1:0] tagArr [`CACHE_LINES];
  memSysPkg::lineDataT dataArr [`CACHE_LINES];
  logic [`CACHE_LINES-1:0] validArr;
  logic [`CACHE_LINES-1:0] dirtyArr;

  memSysPkg::lineAddrT curLine;
  logic [idxBits-1:0] idx;
  logic [tagBits-1:0] tag;
  logic [offBits-1:0] off;
  logic hit;
  logic victimDirty;

  // replace one word of a line
  function automatic memSysPkg::lineDataT setWord(
    memSysPkg::lineDataT line,
    logic [offBits-1:0] wordOff,
    memSysPkg::wordT w
  );
    memSysPkg::lineDataT res;
    res = line;
    res[wordOff*32 +: 32] = w;
    return res;
  endfunction

  assign curLine = curReq.addr[`MEM_WORDS_LOG2+1:offBits+2];
  assign idx = curLine[idxBits-1:0];
  assign tag = curLine[lineBits-1:idxBits];
  assign off = curReq.addr[offBits+1:2];
  assign hit = validArr[idx] && (tagArr[idx] == tag);
  assign victimDirty = validArr[idx] && dirtyArr[idx];

  // one access at a time
  assign reqReady = (state == memSysPkg::CACHE_IDLE);
  assign doneValid = (state == memSysPkg::CACHE_DONE);
  assign doneData = rdData;

  // line requests, held steady while the FIFO is full
  always_comb
  begin
    pushValid = 1'b0;
    push = '0;
    case (state)
      memSysPkg::CACHE_WRITEBACK:
      begin
        // victim address rebuilt from its stored tag
        pushValid = 1'b1;
        push.write = 1'b1;
        push.lineAddr = {tagArr[idx], idx};
        push.data = dataArr[idx];
      end
      memSysPkg::CACHE_FILL:
      begin
        pushValid = 1'b1;
        push.lineAddr = curLine;
      end
      default:
      begin
        pushValid = 1'b0;
      end
    endcase
  end

  // FSM plus valid and dirty bits
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= memSysPkg::CACHE_IDLE;
      validArr <= '0;
      dirtyArr <= '0;
    end
    else
    begin
      case (state)
        memSysPkg::CACHE_IDLE:
        begin
          if (reqValid)
          begin
            state <= memSysPkg::CACHE_LOOKUP;
          end
        end
        memSysPkg::CACHE_LOOKUP:
        begin
          if (hit)
          begin
            state <= memSysPkg::CACHE_DONE;
            if (curReq.write)
            begin
              dirtyArr[idx] <= 1'b1;
            end
          end
          else if (victimDirty)
          begin
            state <= memSysPkg::CACHE_WRITEBACK;
          end
          else
          begin
            state <= memSysPkg::CACHE_FILL;
          end
        end
        memSysPkg::CACHE_WRITEBACK:
        begin
          if (pushReady)
          begin
            state <= memSysPkg::CACHE_FILL;
          end
        end
        memSysPkg::CACHE_FILL:
        begin
          if (pushReady)
          begin
            state <= memSysPkg::CACHE_WAITFILL;
          end
        end
        memSysPkg::CACHE_WAITFILL:
        begin
          // new line is dirty only if a write lands in it
          if (fillValid)
          begin
            state <= memSysPkg::CACHE_DONE;
            validArr[idx] <= 1'b1;
            dirtyArr[idx] <= curReq.write;
          end
        end
        default:
        begin
          state <= memSysPkg::CACHE_IDLE;
        end
      endcase
    end
  end

  // tags, line data, latched request, read word
  always_ff @(posedge clk)
  begin
    if (state == memSysPkg::CACHE_IDLE && reqValid)
    begin
      curReq <= req;
    end
    if (state == memSysPkg::CACHE_LOOKUP && hit)
    begin
      rdData <= dataArr[idx][off*32 +: 32];
      if (curReq.write)
      begin
        dataArr[idx] <= setWord(dataArr[idx], off, curReq.wdata);
      end
    end
    if (state == memSysPkg::CACHE_WAITFILL && fillValid)
    begin
      // install line, merge pending write word
      tagArr[idx] <= tag;
      rdData <= fillData[off*32 +: 32];
      dataArr[idx] <= curReq.write ? setWord(fillData, off, curReq.wdata) : fillData;
    end
  end

endmodule

// ==== memReqFifo.sv ====
`include "memSys_macros.svh"

module memReqFifo
(
  input  logic               clk,
  input  logic               rstN,
  input  logic               pushValid,
  input  memSysPkg::lineReqT push,
  output logic               pushReady,
  output logic               popValid,
  output memSysPkg::lineReqT pop,
  input  logic               popReady
);

  localparam int ptrBits = (`FIFO_DEPTH > 1) ? $clog2(`FIFO_DEPTH) : 1;
  localparam int cntBits = $clog2(`FIFO_DEPTH + 1);
  localparam logic [ptrBits-1:0] lastPtr = ptrBits'(`FIFO_DEPTH - 1);
  localparam logic [cntBits-1:0] fullCnt = cntBits'(`FIFO_DEPTH);

  memSysPkg::lineReqT entries [`FIFO_DEPTH];
  logic [ptrBits-1:0] wrPtr;
  logic [ptrBits-1:0] rdPtr;
  logic [cntBits-1:0] count;
  logic doPush;
  logic doPop;

  // flags straight from occupancy
  assign pushReady = (count != fullCnt);
  assign popValid = (count != '0);
  assign pop = entries[rdPtr];
  assign doPush = pushValid && pushReady;
  assign doPop = popValid && popReady;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      // pointers wrap at depth, which need not be a power of two
      if (doPush)
      begin
        wrPtr <= (wrPtr == lastPtr) ? '0 : wrPtr + 1'b1;
      end
      if (doPop)
      begin
        rdPtr <= (rdPtr == lastPtr) ? '0 : rdPtr + 1'b1;
      end
      if (doPush && !doPop)
      begin
        count <= count + 1'b1;
      end
      else if (doPop && !doPush)
      begin
        count <= count - 1'b1;
      end
    end
  end

  // entry storage
  always_ff @(posedge clk)
  begin
    if (doPush)
    begin
      entries[wrPtr] <= push;
    end
  end

endmodule

// ==== blockMem.sv ====
`include "memSys_macros.svh"

module blockMem
(
  input  logic                clk,
  input  logic                rstN,
  input  logic                popValid,
  input  memSysPkg::lineReqT  pop,
  output logic                popReady,
  output logic                fillValid,
  output memSysPkg::lineDataT fillData
);

  localparam int memWords = 1 << `MEM_WORDS_LOG2;
  localparam int offBits = $clog2(`BLOCK_WORDS);
  localparam int cntBits = $clog2(`WAIT_CYCLES + 1);
  localparam logic [cntBits-1:0] lastCnt = cntBits'(`WAIT_CYCLES - 1);

  memSysPkg::wordT memArr [memWords];
  memSysPkg::memStateT state;
  memSysPkg::lineReqT curReq;
  logic [cntBits-1:0] waitCnt;

  // starts all zero, no image file
  initial
  begin
    for (int i = 0; i < memWords; i++)
    begin
      memArr[i] = '0;
    end
  end

  // one request in flight
  assign popReady = (state == memSysPkg::MEM_IDLE);

  // read pulse only, writebacks stay silent
  assign fillValid = (state == memSysPkg::MEM_RETURN) && !curReq.write;

  // gather the addressed line, word 0 low
  always_comb
  begin
    for (int w = 0; w < `BLOCK_WORDS; w++)
    begin
      fillData[w*32 +: 32] = memArr[{curReq.lineAddr, offBits'(w)}];
    end
  end

  // pop at t, WAITING for WAIT_CYCLES, RETURN at t+WAIT_CYCLES+1
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= memSysPkg::MEM_IDLE;
      waitCnt <= '0;
    end
    else
    begin
      case (state)
        memSysPkg::MEM_IDLE:
        begin
          waitCnt <= '0;
          if (popValid)
          begin
            state <= memSysPkg::MEM_WAITING;
          end
        end
        memSysPkg::MEM_WAITING:
        begin
          if (waitCnt == lastCnt)
          begin
            state <= memSysPkg::MEM_RETURN;
          end
          else
          begin
            waitCnt <= waitCnt + 1'b1;
          end
        end
        default:
        begin
          state <= memSysPkg::MEM_IDLE;
        end
      endcase
    end
  end

  // latch the accepted request
  always_ff @(posedge clk)
  begin
    if (popValid && popReady)
    begin
      curReq <= pop;
    end
  end

  // whole-line write in RETURN
  always @(posedge clk)
  begin
    if (state == memSysPkg::MEM_RETURN && curReq.write)
    begin
      for (int w = 0; w < `BLOCK_WORDS; w++)
      begin
        memArr[{curReq.lineAddr, offBits'(w)}] <= curReq.data[w*32 +: 32];
      end
    end
  end

endmodule

// ==== memSubsystem.sv ====
module memSubsystem
(
  input  logic                clk,
  input  logic                rstN,
  input  logic                awvalid,
  output logic                awready,
  input  memSysPkg::byteAddrT awaddr,
  input  logic                wvalid,
  output logic                wready,
  input  memSysPkg::wordT     wdata,
  output logic                bvalid,
  input  logic                bready,
  input  logic                arvalid,
  output logic                arready,
  input  memSysPkg::byteAddrT araddr,
  output logic                rvalid,
  input  logic                rready,
  output memSysPkg::wordT     rdata
);

  // slave port to cache
  logic reqValid;
  logic reqReady;
  memSysPkg::wordReqT req;
  logic doneValid;
  memSysPkg::wordT doneData;

  // cache to FIFO
  logic pushValid;
  logic pushReady;
  memSysPkg::lineReqT push;

  // FIFO to memory
  logic popValid;
  logic popReady;
  memSysPkg::lineReqT pop;

  // fill return, memory to cache
  logic fillValid;
  memSysPkg::lineDataT fillData;

  axiLiteSlave uSlave (
    .clk(clk), .rstN(rstN),
    .awvalid(awvalid), .awaddr(awaddr), .wvalid(wvalid), .wdata(wdata),
    .arvalid(arvalid), .araddr(araddr), .bready(bready), .rready(rready),
    .awready(awready), .wready(wready), .arready(arready),
    .bvalid(bvalid), .rvalid(rvalid), .rdata(rdata),
    .reqValid(reqValid), .req(req), .reqReady(reqReady),
    .doneValid(doneValid), .doneData(doneData)
  );

  cacheCtrl uCache (
    .clk(clk), .rstN(rstN),
    .reqValid(reqValid), .req(req), .reqReady(reqReady),
    .doneValid(doneValid), .doneData(doneData),
    .pushValid(pushValid), .push(push), .pushReady(pushReady),
    .fillValid(fillValid), .fillData(fillData)
  );

  memReqFifo uFifo (
    .clk(clk), .rstN(rstN),
    .pushValid(pushValid), .push(push), .pushReady(pushReady),
    .popValid(popValid), .pop(pop), .popReady(popReady)
  );

  blockMem uMem (
    .clk(clk), .rstN(rstN),
    .popValid(popValid), .pop(pop), .popReady(popReady),
    .fillValid(fillValid), .fillData(fillData)
  );

endmodule

// ==== tbMemSubsystem.sv ====
module tbMemSubsystem;

  localparam int maxVecs = 64;
  localparam int vecFields = 5;

  logic clk;
  logic rstN;
  logic awvalid;
  logic awready;
  memSysPkg::byteAddrT awaddr;
  logic wvalid;
  logic wready;
  memSysPkg::wordT wdata;
  logic bvalid;
  logic bready;
  logic arvalid;
  logic arready;
  memSysPkg::byteAddrT araddr;
  logic rvalid;
  logic rready;
  memSysPkg::wordT rdata;

  // five hex words per vector in data file column order
  logic [31:0] vecMem [0:maxVecs*vecFields-1];
  int numVecs;
  int errors;
  int checksRun;
  logic loaded;
  logic [31:0] lcgState;

  memSubsystem DUT (
    .clk(clk), .rstN(rstN),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata),
    .bvalid(bvalid), .bready(bready),
    .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rdata(rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #5 clk = ~clk;
    end
  end

  // stall length source
  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checksRun++;
    if (actual !== expected)
    begin
      errors++;
      $display("ERROR %s: expected %08h, actual %08h", name, expected, actual);
    end
  endtask

  // failure described in plain words
  task automatic reportProblem(input string what);
    errors++;
    $display("problem: %s", what);
  endtask

  // waits for the B or R response and takes it once after a stall
  task automatic takeResponse(input logic isWrite, output memSysPkg::wordT data);
    int stall;
    logic seen;
    stall = (nextRand() >> 16) % 4;
    seen = 1'b0;
    while (!seen)
    begin
      @(negedge clk);
      seen = isWrite ? bvalid : rvalid;
      if (isWrite ? rvalid : bvalid)
      begin
        reportProblem("response came back on the wrong channel");
      end
    end
    // probe the read address channel while the response waits
    for (int i = 0; i < stall; i++)
    begin
      @(posedge clk);
      #1;
      arvalid = 1'b1;
      araddr = 32'h0000_3000 + 32'(i * 4);
      @(negedge clk);
      if (arready || awready || wready)
      begin
        reportProblem("an address was accepted while a response was pending");
      end
      if (!(isWrite ? bvalid : rvalid))
      begin
        reportProblem("response dropped before the master took it");
      end
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    bready = isWrite;
    rready = !isWrite;
    @(negedge clk);
    data = rdata;
    @(posedge clk);
    #1;
    bready = 1'b0;
    rready = 1'b0;
    // one handshake only
    @(negedge clk);
    if (bvalid || rvalid)
    begin
      reportProblem("response still valid after the handshake");
    end
    @(posedge clk);
    #1;
  endtask

  task automatic doWrite(input memSysPkg::byteAddrT addr, input memSysPkg::wordT data);
    logic got;
    memSysPkg::wordT unused;
    awvalid = 1'b1;
    awaddr = addr;
    wvalid = 1'b1;
    wdata = data;
    got = 1'b0;
    while (!got)
    begin
      @(negedge clk);
      got = awready && wready;
      @(posedge clk);
      #1;
    end
    awvalid = 1'b0;
    wvalid = 1'b0;
    takeResponse(1'b1, unused);
  endtask

  task automatic doRead(input memSysPkg::byteAddrT addr, output memSysPkg::wordT data);
    logic got;
    arvalid = 1'b1;
    araddr = addr;
    got = 1'b0;
    while (!got)
    begin
      @(negedge clk);
      got = arready;
      @(posedge clk);
      #1;
    end
    arvalid = 1'b0;
    takeResponse(1'b0, data);
  endtask

  // outputs quiet during reset and the cycle after
  task automatic checkQuiet(input string when);
    if (awready || wready || arready || bvalid || rvalid)
    begin
      reportProblem({"ready or valid output high ", when});
    end
  endtask

  initial
  begin
    logic [31:0] num;
    logic [31:0] addr;
    memSysPkg::wordT got;
    rstN = 1'b0;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    arvalid = 1'b0;
    araddr = '0;
    bready = 1'b0;
    rready = 1'b0;
    errors = 0;
    checksRun = 0;
    loaded = 1'b0;
    lcgState = 32'h2d9;
    $readmemh("tb_input.txt", vecMem);
    numVecs = 0;
    while (numVecs < maxVecs && !$isunknown(vecMem[numVecs*vecFields]))
    begin
      numVecs++;
    end
    if (numVecs == 0)
    begin
      reportProblem("no test vectors were read from tb_input.txt");
    end
    loaded = 1'b1;
    repeat (16)
    begin
      @(negedge clk);
      checkQuiet("during reset");
      @(posedge clk);
    end
    #1;
    rstN = 1'b1;
    @(negedge clk);
    checkQuiet("in the first cycle after reset");
    @(posedge clk);
    #1;
    for (int v = 0; v < numVecs; v++)
    begin
      num = vecMem[v*vecFields];
      addr = vecMem[v*vecFields+2];
      if (vecMem[v*vecFields+1] == 32'd1)
      begin
        doWrite(addr, vecMem[v*vecFields+3]);
      end
      else
      begin
        doRead(addr, got);
        checkValue($sformatf("test %0h read %08h", num, addr),
                   vecMem[v*vecFields+4], got);
      end
    end
    repeat (4) @(posedge clk);
    $display("checks run: %0d, errors: %0d", checksRun, errors);
    if (errors == 0)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  end

  // budget of 200 cycles per vector plus reset
  initial
  begin
    wait (loaded);
    repeat (numVecs * 200 + 20) @(posedge clk);
    $display("watchdog: the run hung and did not finish its vectors in time");
    $display("checks run: %0d, errors: %0d", checksRun, errors + 1);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== tb_input.txt ====
// columns: test number, op (1 write, 0 read), byte address, write data, expected read data
// all fields hex, expected read data is ignored for writes
01 0 00000040 00000000 00000000
02 1 00000200 a5a50001 00000000
03 0 00000200 00000000 a5a50001
04 0 00000204 00000000 00000000
05 1 00000100 12345678 00000000
06 0 00000180 00000000 00000000
07 0 00000100 00000000 12345678
08 0 00000200 00000000 a5a50001
09 1 00000010 11110010 00000000
0a 1 00000090 22220090 00000000
0b 1 0000001c 1111001c 00000000
0c 0 00000010 00000000 11110010
0d 0 00000094 00000000 00000000
0e 0 00000090 00000000 22220090
0f 1 00003ff0 ffff3ff0 00000000
10 1 00000070 77770070 00000000
11 0 00003ff0 00000000 ffff3ff0
12 0 0000001c 00000000 1111001c
13 1 00000020 20202020 00000000
14 1 00000024 20202024 00000000
15 1 00000028 20202028 00000000
16 1 0000002c 2020202c 00000000
17 0 00000028 00000000 20202028
18 1 000000a0 a0a0a0a0 00000000
19 0 00000020 00000000 20202020
1a 0 000000a0 00000000 a0a0a0a0
1b 1 00000020 deadbeef 00000000
1c 0 00000020 00000000 deadbeef
1d 0 00000024 00000000 20202024
1e 0 00000070 00000000 77770070
1f 0 00000100 00000000 12345678
20 0 00000ff8 00000000 00000000

// ==== sim.f ====
+incdir+.
memSysPkg.sv
axiLiteSlave.sv
cacheCtrl.sv
memReqFifo.sv
blockMem.sv
memSubsystem.sv
tbMemSubsystem.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

export_include_dirs:
  - .

sources:
  - memSysPkg.sv
  - axiLiteSlave.sv
  - cacheCtrl.sv
  - memReqFifo.sv
  - blockMem.sv
  - memSubsystem.sv
  - target: test
    files:
      - tbMemSubsystem.sv
